//--- holoblade_bridge.f
+incdir+dv
source/bridge_pkg.sv
source/spi_req_if.sv
source/uart_rx.sv
source/byte_pairer.sv
source/spi_master.sv
source/reply_fifo.sv
source/uart_tx.sv
source/holoblade_bridge.sv
dv/tb_holoblade_bridge.sv

//--- run_sim.sh
#!/bin/sh
# build and run the bridge testbench with Verilator, log decides pass or fail
rm -f sim.log
{ verilator --binary --timing --timescale 1ns/1ps --top-module tb_holoblade_bridge \
    -f holoblade_bridge.f && ./obj_dir/Vtb_holoblade_bridge; } > sim.log 2>&1 \
  || echo "build or simulation exited with a nonzero status" >> sim.log
cat sim.log
grep -q "Finished with errors" sim.log && exit 1
grep -q "Finished with no errors" sim.log || exit 1
exit 0

//--- dv/tb_tasks.svh
////////////////////////////////////////
// testbench tasks
// uart host side, checks, directed tests
////////////////////////////////////////

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // n edges on, then the drive offset
  task automatic step_cycles(input int n);
    repeat (n) @(posedge sys_clk);
    #(DRIVE_DLY);
  endtask

  ////////////////////////////////////////
  // uart host
  ////////////////////////////////////////

  // 8N1, lsb first, one idle cycle ahead
  task automatic send_byte(input byte_t data);
    byte_t shift;
    shift = data;
    step_cycles(1);
    uart_rx_i = 1'b0;
    step_cycles(CLKS_PER_BIT);
    for (int i = 0; i < UART_DATA_BITS; i++) begin
      uart_rx_i = shift[0];
      shift     = shift >> 1;
      step_cycles(CLKS_PER_BIT);
    end
    uart_rx_i = 1'b1;
    step_cycles(CLKS_PER_BIT);
  endtask

  // returns in the middle of the stop bit
  task automatic get_byte(output byte_t data);
    int    waited;
    byte_t shift;
    waited = 0;
    shift  = '0;
    while (uart_tx_o !== 1'b0) begin
      if (waited == REPLY_TIMEOUT) begin
        fail_now("Timed out waiting for a start bit on uart_tx_o");
      end
      step_cycles(1);
      waited++;
    end
    step_cycles(CLKS_PER_BIT / 2);
    if (uart_tx_o !== 1'b0) begin
      fail_now("Start bit on uart_tx_o ended before its middle");
    end
    for (int i = 0; i < UART_DATA_BITS; i++) begin
      step_cycles(CLKS_PER_BIT);
      shift = {uart_tx_o, shift[UART_DATA_BITS-1:1]};
    end
    step_cycles(CLKS_PER_BIT);
    if (uart_tx_o !== 1'b1) begin
      fail_now("Stop bit on uart_tx_o is not high");
    end
    data = shift;
  endtask

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic compare_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      fail_now($sformatf("Fail at %0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  task automatic compare_count(input int got, input int exp, input string what);
    if (got != exp) begin
      fail_now($sformatf("Fail at %0t: %s got %0d expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic compare_byte(input byte_t got, input byte_t exp, input string what);
    if (got !== exp) begin
      fail_now($sformatf("Fail at %0t: %s got %02h expected %02h", $time, what, got, exp));
    end
  endtask

  task automatic compare_frame(input spi_frame_u got, input spi_frame_u exp,
                               input string what);
    if (got.raw !== exp.raw) begin
      fail_now($sformatf("Fail at %0t: %s got addr %02h data %02h expected %02h %02h",
                         $time, what, got.fields.addr, got.fields.data,
                         exp.fields.addr, exp.fields.data));
    end
  endtask

  // oldest logged frame against address and data bytes
  task automatic check_frame(input byte_t addr, input byte_t data);
    spi_frame_u exp;
    exp.fields.addr = addr;
    exp.fields.data = data;
    if (frame_log.size() == 0) begin
      fail_now("Expected SPI frame was never seen");
    end
    compare_frame(frame_log.pop_front(), exp, "spi frame");
    compare_count(edge_log.pop_front(), SPI_FRAME_BITS, "sclk rising edges");
  endtask

  // reply is the low byte of the slave pattern
  task automatic check_reply(input byte_t got);
    if (miso_low_log.size() == 0) begin
      fail_now("Reply arrived with no SPI frame behind it");
    end
    compare_byte(got, miso_low_log.pop_front(), "reply byte");
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic test_idle_after_reset();
    for (int i = 0; i < 50; i++) begin
      compare_bit(uart_tx_o, 1'b1, "uart_tx_o idle");
      compare_bit(spi_cs_n_o, 1'b1, "spi_cs_n_o idle");
      compare_bit(spi_sclk_o, 1'b0, "spi_sclk_o idle");
      step_cycles(1);
    end
    compare_count(frame_log.size(), 0, "frames after reset");
  endtask

  task automatic test_pair_frame();
    byte_t reply;
    send_byte(8'hA5);
    send_byte(8'h3C);
    get_byte(reply);
    check_frame(8'hA5, 8'h3C);
    check_reply(reply);
    compare_count(frame_log.size(), 0, "frames for one pair");
  endtask

  task automatic test_single_byte_waits();
    byte_t reply;
    send_byte(8'h42);
    step_cycles(30 * CHAR_CYCLES);
    compare_count(frame_log.size(), 0, "frames after a single byte");
    compare_bit(spi_cs_n_o, 1'b1, "spi_cs_n_o after a single byte");
    send_byte(8'hE7);
    get_byte(reply);
    check_frame(8'h42, 8'hE7);
    check_reply(reply);
  endtask

  task automatic test_reply_byte();
    byte_t reply;
    send_byte(8'h81);
    send_byte(8'h7E);
    get_byte(reply);
    check_reply(reply);
    check_frame(8'h81, 8'h7E);
  endtask

  // replies drain while the next pairs are still coming in
  task automatic test_back_to_back_pairs();
    byte_t tx_bytes[6];
    byte_t replies[3];
    for (int i = 0; i < 6; i++) begin
      rng_state   = lcg_next(rng_state);
      tx_bytes[i] = rng_state[23:16];
    end
    fork
      begin
        for (int i = 0; i < 6; i++) begin
          send_byte(tx_bytes[i]);
        end
      end
      begin
        for (int j = 0; j < 3; j++) begin
          get_byte(replies[j]);
        end
      end
    join
    for (int k = 0; k < 3; k++) begin
      check_frame(tx_bytes[2*k], tx_bytes[2*k+1]);
      check_reply(replies[k]);
    end
    compare_count(frame_log.size(), 0, "extra frames after three pairs");
  endtask

  // half a pair, then reset
  task automatic test_reset_mid_pair();
    byte_t reply;
    send_byte(8'h99);
    reset_all_cmd_w = 1'b1;
    step_cycles(5);
    reset_all_cmd_w = 1'b0;
    send_byte(8'h12);
    send_byte(8'h34);
    get_byte(reply);
    check_frame(8'h12, 8'h34);
    check_reply(reply);
    compare_count(frame_log.size(), 0, "frames after reset mid pair");
  endtask

`endif

//--- dv/tb_holoblade_bridge.sv
////////////////////////////////////////
// holoblade bridge testbench
// uart host, spi slave model, watchdog
////////////////////////////////////////

`timescale 1ns/1ps

module tb_holoblade_bridge;
  import bridge_pkg::*;

  localparam int CLK_HALF      = 5;
  localparam int DRIVE_DLY     = 1;
  localparam int CLKS_PER_BIT  = 8;
  // start, 8 data, stop
  localparam int CHAR_CYCLES   = 10 * CLKS_PER_BIT;
  localparam int REPLY_TIMEOUT = 40 * CHAR_CYCLES;
  localparam int NUM_TESTS     = 6;
  // 40 character times per test, 10 ns per cycle
  localparam int WATCHDOG_NS   = NUM_TESTS * 40 * CHAR_CYCLES * 2 * CLK_HALF;

  logic sys_clk;
  logic reset_all_cmd_w;
  logic uart_rx_i;
  logic spi_miso_i;
  logic uart_tx_o;
  logic spi_cs_n_o;
  logic spi_sclk_o;
  logic spi_mosi_o;

  // slave model state
  logic [31:0] rng_state;
  logic [15:0] miso_word;
  logic [15:0] mosi_shift;
  byte_t       miso_expect;
  spi_frame_u  frame_seen;
  int          miso_idx;
  int          rise_cnt;
  logic        in_frame;

  // one entry per finished frame
  spi_frame_u  frame_log[$];
  int          edge_log[$];
  byte_t       miso_low_log[$];

  holoblade_bridge #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_holoblade_bridge (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx_i),
    .spi_miso_i      (spi_miso_i),
    .uart_tx_o       (uart_tx_o),
    .spi_cs_n_o      (spi_cs_n_o),
    .spi_sclk_o      (spi_sclk_o),
    .spi_mosi_o      (spi_mosi_o)
  );

  always #(CLK_HALF) sys_clk = ~sys_clk;

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "run stopped at the first error");
  endtask

  `include "tb_tasks.svh"

  ////////////////////////////////////////
  // spi slave model
  ////////////////////////////////////////

  // chip select low, fresh pattern, msb out first
  always @(negedge spi_cs_n_o) begin
    if (spi_cs_n_o === 1'b0) begin
      rng_state   = lcg_next(rng_state);
      miso_word   = rng_state[31:16];
      miso_expect = miso_word[7:0];
      mosi_shift  = '0;
      rise_cnt    = 0;
      miso_idx    = 0;
      in_frame    = 1'b1;
      #(DRIVE_DLY);
      spi_miso_i  = miso_word[15];
    end
  end

  // mosi captured on rising sclk
  always @(posedge spi_sclk_o) begin
    mosi_shift = {mosi_shift[14:0], spi_mosi_o};
    rise_cnt   = rise_cnt + 1;
  end

  // next miso bit on falling sclk, none after the last
  always @(negedge spi_sclk_o) begin
    if (miso_idx < 15) begin
      miso_idx  = miso_idx + 1;
      miso_word = {miso_word[14:0], 1'b0};
      #(DRIVE_DLY);
      spi_miso_i = miso_word[15];
    end
  end

  // chip select high closes the frame
  always @(posedge spi_cs_n_o) begin
    if (in_frame) begin
      in_frame       = 1'b0;
      frame_seen.raw = mosi_shift;
      frame_log.push_back(frame_seen);
      edge_log.push_back(rise_cnt);
      miso_low_log.push_back(miso_expect);
    end
  end

  initial begin
    #(WATCHDOG_NS);
    fail_now("Watchdog expired before the tests finished");
  end

  initial begin
    sys_clk         = 1'b0;
    reset_all_cmd_w = 1'b1;
    uart_rx_i       = 1'b1;
    spi_miso_i      = 1'b0;
    rng_state       = 32'h2902;
    miso_word       = '0;
    mosi_shift      = '0;
    miso_expect     = '0;
    miso_idx        = 15;
    rise_cnt        = 0;
    in_frame        = 1'b0;
    repeat (5) @(posedge sys_clk);
    #(DRIVE_DLY);
    reset_all_cmd_w = 1'b0;
    test_idle_after_reset();
    test_pair_frame();
    test_single_byte_waits();
    test_reply_byte();
    test_back_to_back_pairs();
    test_reset_mid_pair();
    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- source/holoblade_bridge.sv
////////////////////////////////////////
// holoblade bridge top
// uart command bytes in, spi frames out, spi replies back over uart
////////////////////////////////////////

`timescale 1ns/1ps

module holoblade_bridge #(
  parameter int CLKS_PER_BIT = 434,
  parameter int SPI_CLK_DIV  = 2,
  parameter int FIFO_DEPTH   = 4
) (
  input  logic sys_clk,
  input  logic reset_all_cmd_w,
  input  logic uart_rx_i,
  input  logic spi_miso_i,
  output logic uart_tx_o,
  output logic spi_cs_n_o,
  output logic spi_sclk_o,
  output logic spi_mosi_o
);
  import bridge_pkg::*;

  logic  rx_valid_w;
  byte_t rx_byte_w;
  logic  fifo_empty_w;
  byte_t head_byte_w;
  logic  pop_w;

  spi_req_if spi_req_bus ();

  ////////////////////////////////////////
  // input side
  ////////////////////////////////////////

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_rx (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_serial_i     (uart_rx_i),
    .rx_valid_o      (rx_valid_w),
    .rx_byte_o       (rx_byte_w)
  );

  byte_pairer i_byte_pairer (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_valid_i      (rx_valid_w),
    .rx_byte_i       (rx_byte_w),
    .spi_req         (spi_req_bus)
  );

  ////////////////////////////////////////
  // spi and reply path
  ////////////////////////////////////////

  spi_master #(.SPI_CLK_DIV(SPI_CLK_DIV)) i_spi_master (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .spi_req         (spi_req_bus),
    .spi_miso_i      (spi_miso_i),
    .spi_cs_n_o      (spi_cs_n_o),
    .spi_sclk_o      (spi_sclk_o),
    .spi_mosi_o      (spi_mosi_o)
  );

  reply_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_reply_fifo (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .spi_mon         (spi_req_bus),
    .pop_i           (pop_w),
    .empty_o         (fifo_empty_w),
    .head_byte_o     (head_byte_w)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_tx (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .empty_i         (fifo_empty_w),
    .head_byte_i     (head_byte_w),
    .pop_o           (pop_w),
    .tx_serial_o     (uart_tx_o)
  );

endmodule

//--- source/uart_tx.sv
////////////////////////////////////////
// uart transmitter
// pops queued replies and sends them 8N1
////////////////////////////////////////

`timescale 1ns/1ps

module uart_tx #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic              sys_clk,
  input  logic              reset_all_cmd_w,
  input  logic              empty_i,
  input  bridge_pkg::byte_t head_byte_i,
  output logic              pop_o,
  output logic              tx_serial_o
);
  import bridge_pkg::*;

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam int BIT_W = $clog2(UART_DATA_BITS);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_START = 2'd1;
  localparam logic [1:0] ST_DATA  = 2'd2;
  localparam logic [1:0] ST_STOP  = 2'd3;

  logic [1:0]       state_q;
  logic [CNT_W-1:0] clk_cnt_q;
  logic [BIT_W-1:0] bit_idx_q;
  logic             tx_q;
  byte_t            shift_q;
  logic             bit_end_w;

  assign bit_end_w = clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1);
  // pop only from idle
  assign pop_o     = (state_q == ST_IDLE) && !empty_i;

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state_q   <= ST_IDLE;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
      tx_q      <= 1'b1;
    end else begin
      clk_cnt_q <= bit_end_w ? '0 : clk_cnt_q + 1'b1;
      case (state_q)
        ST_IDLE: begin
          clk_cnt_q <= '0;
          bit_idx_q <= '0;
          tx_q      <= !pop_o;
          if (pop_o) begin
            state_q <= ST_START;
          end
        end
        ST_START: begin
          if (bit_end_w) begin
            tx_q    <= shift_q[0];
            state_q <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (bit_end_w) begin
            bit_idx_q <= bit_idx_q + 1'b1;
            // shift_q already moved on by one
            tx_q      <= shift_q[0];
            if (bit_idx_q == BIT_W'(UART_DATA_BITS - 1)) begin
              tx_q    <= 1'b1;
              state_q <= ST_STOP;
            end
          end
        end
        default: begin
          if (bit_end_w) begin
            state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // latch on pop, lsb first out
  always_ff @(posedge sys_clk) begin
    if (pop_o) begin
      shift_q <= head_byte_i;
    end else if (bit_end_w && (state_q == ST_START || state_q == ST_DATA)) begin
      shift_q <= {1'b0, shift_q[UART_DATA_BITS-1:1]};
    end
  end

  assign tx_serial_o = tx_q;

endmodule

//--- source/reply_fifo.sv
////////////////////////////////////////
// reply fifo
// queues spi reply bytes for the uart transmitter
////////////////////////////////////////

`timescale 1ns/1ps

module reply_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic              sys_clk,
  input  logic              reset_all_cmd_w,
  spi_req_if.monitor        spi_mon,
  input  logic              pop_i,
  output logic              empty_o,
  output bridge_pkg::byte_t head_byte_o
);
  import bridge_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  byte_t            mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             busy_q;
  logic             fall_q;
  logic             full_w;
  logic             push_w;
  logic             pop_w;

  // circular pointer step
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_w  = count_q == CNT_W'(FIFO_DEPTH);
  assign empty_o = count_q == '0;
  // full fifo drops the reply
  assign push_w  = fall_q && !full_w;
  assign pop_w   = pop_i && !empty_o;

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      busy_q   <= 1'b0;
      fall_q   <= 1'b0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // busy falling edge marks a finished transfer
      busy_q <= spi_mon.busy;
      fall_q <= busy_q && !spi_mon.busy;
      if (push_w) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_w) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push_w, pop_w})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // storage
  always_ff @(posedge sys_clk) begin
    if (push_w) begin
      mem_q[wr_ptr_q] <= spi_mon.rx_byte;
    end
  end

  assign head_byte_o = mem_q[rd_ptr_q];

endmodule

//--- source/spi_master.sv
////////////////////////////////////////
// spi master
// 16 bit mode 0 transfer, captures the returned byte
////////////////////////////////////////

`timescale 1ns/1ps

module spi_master #(
  parameter int SPI_CLK_DIV = 2
) (
  input  logic      sys_clk,
  input  logic      reset_all_cmd_w,
  spi_req_if.engine spi_req,
  input  logic      spi_miso_i,
  output logic      spi_cs_n_o,
  output logic      spi_sclk_o,
  output logic      spi_mosi_o
);
  import bridge_pkg::*;

  localparam int DIV_W  = $clog2(SPI_CLK_DIV + 1);
  localparam int EDGE_W = $clog2(2 * SPI_FRAME_BITS);

  logic                      busy_q;
  logic                      cs_n_q;
  logic                      sclk_q;
  logic                      mosi_q;
  logic [DIV_W-1:0]          div_cnt_q;
  logic [EDGE_W-1:0]         edge_cnt_q;
  logic [SPI_FRAME_BITS-1:0] tx_shift_q;
  byte_t                     rx_shift_q;
  logic                      half_done_w;

  // end of one sclk half period
  assign half_done_w = div_cnt_q == DIV_W'(SPI_CLK_DIV - 1);

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      busy_q     <= 1'b0;
      cs_n_q     <= 1'b1;
      sclk_q     <= 1'b0;
      mosi_q     <= 1'b0;
      div_cnt_q  <= '0;
      edge_cnt_q <= '0;
    end else if (!busy_q) begin
      // start while busy never reaches here
      if (spi_req.start) begin
        busy_q     <= 1'b1;
        cs_n_q     <= 1'b0;
        // first bit ready before first rising edge
        mosi_q     <= spi_req.frame.raw[SPI_FRAME_BITS-1];
        div_cnt_q  <= '0;
        edge_cnt_q <= '0;
      end
    end else if (half_done_w) begin
      div_cnt_q  <= '0;
      sclk_q     <= ~sclk_q;
      edge_cnt_q <= edge_cnt_q + 1'b1;
      // falling edge, next bit out
      if (sclk_q) begin
        if (edge_cnt_q == EDGE_W'(2 * SPI_FRAME_BITS - 1)) begin
          // last falling edge closes the frame
          busy_q <= 1'b0;
          cs_n_q <= 1'b1;
          mosi_q <= 1'b0;
        end else begin
          mosi_q <= tx_shift_q[SPI_FRAME_BITS-2];
        end
      end
    end else begin
      div_cnt_q <= div_cnt_q + 1'b1;
    end
  end

  ////////////////////////////////////////
  // shift registers
  ////////////////////////////////////////

  always_ff @(posedge sys_clk) begin
    if (!busy_q && spi_req.start) begin
      tx_shift_q <= spi_req.frame.raw;
    end else if (busy_q && half_done_w && sclk_q) begin
      tx_shift_q <= {tx_shift_q[SPI_FRAME_BITS-2:0], 1'b0};
    end
    // miso sampled on rising edges, last 8 kept
    if (busy_q && half_done_w && !sclk_q) begin
      rx_shift_q <= {rx_shift_q[$bits(byte_t)-2:0], spi_miso_i};
    end
  end

  assign spi_req.busy    = busy_q;
  assign spi_req.rx_byte = rx_shift_q;
  assign spi_cs_n_o      = cs_n_q;
  assign spi_sclk_o      = sclk_q;
  assign spi_mosi_o      = mosi_q;

endmodule

//--- source/byte_pairer.sv
////////////////////////////////////////
// byte pairer
// builds address/data frames from received bytes
////////////////////////////////////////

`timescale 1ns/1ps

module byte_pairer (
  input  logic              sys_clk,
  input  logic              reset_all_cmd_w,
  input  logic              rx_valid_i,
  input  bridge_pkg::byte_t rx_byte_i,
  spi_req_if.requester      spi_req
);
  import bridge_pkg::*;

  spi_frame_u frame_q;
  // high once the first byte of a pair is in
  logic       parity_q;
  logic       start_q;

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      // back to first byte
      parity_q <= 1'b0;
      start_q  <= 1'b0;
    end else begin
      start_q <= 1'b0;
      if (rx_valid_i) begin
        parity_q <= ~parity_q;
        // second byte completes the pair
        start_q  <= parity_q;
      end
    end
  end

  // old data slides into address, new byte lands in data
  always_ff @(posedge sys_clk) begin
    if (rx_valid_i) begin
      frame_q.fields.addr <= frame_q.fields.data;
      frame_q.fields.data <= rx_byte_i;
    end
  end

  // frame settles on the same edge that raises start
  assign spi_req.start = start_q;
  assign spi_req.frame = frame_q;

endmodule

//--- source/uart_rx.sv
////////////////////////////////////////
// uart receiver
// oversampled 8N1 receive, byte plus one-cycle valid
////////////////////////////////////////

`timescale 1ns/1ps

module uart_rx #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic              sys_clk,
  input  logic              reset_all_cmd_w,
  input  logic              rx_serial_i,
  output logic              rx_valid_o,
  output bridge_pkg::byte_t rx_byte_o
);
  import bridge_pkg::*;

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam int BIT_W = $clog2(UART_DATA_BITS);

  // fsm states
  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_START = 2'd1;
  localparam logic [1:0] ST_DATA  = 2'd2;
  localparam logic [1:0] ST_STOP  = 2'd3;

  logic [1:0]       sync_q;
  logic [1:0]       state_q;
  logic [CNT_W-1:0] clk_cnt_q;
  logic [BIT_W-1:0] bit_idx_q;
  logic             valid_q;
  byte_t            shift_q;
  logic             line_w;
  logic             bit_end_w;

  // two flop synchronizer output
  assign line_w    = sync_q[1];
  // middle of a data or stop bit
  assign bit_end_w = clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1);

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      // line idles high
      sync_q    <= 2'b11;
      state_q   <= ST_IDLE;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      sync_q    <= {sync_q[0], rx_serial_i};
      valid_q   <= 1'b0;
      clk_cnt_q <= clk_cnt_q + 1'b1;
      case (state_q)
        ST_IDLE: begin
          clk_cnt_q <= '0;
          bit_idx_q <= '0;
          if (!line_w) begin
            state_q <= ST_START;
          end
        end
        ST_START: begin
          // half a bit in, recheck start bit
          if (clk_cnt_q == CNT_W'((CLKS_PER_BIT - 1) / 2)) begin
            clk_cnt_q <= '0;
            state_q   <= line_w ? ST_IDLE : ST_DATA;
          end
        end
        ST_DATA: begin
          if (bit_end_w) begin
            clk_cnt_q <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == BIT_W'(UART_DATA_BITS - 1)) begin
              state_q <= ST_STOP;
            end
          end
        end
        default: begin
          // stop bit must be high, else framing error and byte dropped
          if (bit_end_w) begin
            valid_q <= line_w;
            state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // lsb first, sampled mid bit
  always_ff @(posedge sys_clk) begin
    if (state_q == ST_DATA && bit_end_w) begin
      shift_q <= {line_w, shift_q[UART_DATA_BITS-1:1]};
    end
  end

  assign rx_valid_o = valid_q;
  assign rx_byte_o  = shift_q;

endmodule

//--- source/spi_req_if.sv
////////////////////////////////////////
// spi request interface
// transfer request from the pairer, status and reply from the master
////////////////////////////////////////

`timescale 1ns/1ps

interface spi_req_if;
  import bridge_pkg::*;

  // request side
  logic       start;
  spi_frame_u frame;
  // engine side
  logic       busy;
  byte_t      rx_byte;

  modport requester (output start, output frame);
  modport engine    (input start, input frame, output busy, output rx_byte);
  modport monitor   (input busy, input rx_byte);
endinterface

//--- source/bridge_pkg.sv
////////////////////////////////////////
// bridge package
// widths and types shared by the UART to SPI command bridge
////////////////////////////////////////

package bridge_pkg;

  // bits per UART character, no parity
  localparam int UART_DATA_BITS = 8;

  // one SPI frame is address byte then data byte
  localparam int SPI_FRAME_BITS = 16;

  // one byte on either link
  typedef logic [7:0] byte_t;

  // spi frame, seen as a raw shift word or as two bytes
  typedef union packed {
    // shifted out MSB first
    logic [SPI_FRAME_BITS-1:0] raw;
    // filled by the pairer
    struct packed {
      byte_t addr;
      byte_t data;
    } fields;
  } spi_frame_u;

endpackage
